/* logic/tile_pkg.sv */
`default_nettype none

package tile_pkg;

  localparam int cord_w = 4;
  localparam int addr_w = 8;
  localparam int data_w = 32;
  localparam int sys_w  = 16;
  localparam int op_w   = 2;
  localparam int dirs   = 5;   // proc plus four mesh links

  // port index, proc first as on the mesh node
  typedef enum logic [2:0] {
    dir_proc  = 3'd0,
    dir_west  = 3'd1,
    dir_east  = 3'd2,
    dir_north = 3'd3,
    dir_south = 3'd4
  } dir_e;

  typedef enum logic [op_w-1:0] {
    op_write = 2'd0,
    op_read  = 2'd1,
    op_resp  = 2'd2
  } op_e;

  // packet layout, msb to lsb: op, dst_x, dst_y, src_x, src_y, addr, data
  localparam int data_lsb  = 0;
  localparam int addr_lsb  = data_lsb + data_w;
  localparam int src_y_lsb = addr_lsb + addr_w;
  localparam int src_x_lsb = src_y_lsb + cord_w;
  localparam int dst_y_lsb = src_x_lsb + cord_w;
  localparam int dst_x_lsb = dst_y_lsb + cord_w;
  localparam int op_lsb    = dst_x_lsb + cord_w;
  localparam int pkt_w     = op_lsb + op_w;   // 58

  // accumulator window in the remote address space
  localparam logic [addr_w-1:0] acc_addr = 8'hFF;

endpackage

`default_nettype wire

/* logic/link_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module link_fifo #(
  parameter int width_p = 58,
  parameter int els_p   = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               val_i,
  input  logic [width_p-1:0] data_i,
  output logic               rdy_o,
  output logic               val_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  localparam int ptr_w = $clog2(els_p);

  logic [width_p-1:0] mem_r [els_p];
  logic [ptr_w-1:0]   rd_ptr_r;
  logic [ptr_w-1:0]   wr_ptr_r;
  logic [ptr_w-1:0]   wr_ptr_nxt;
  logic               full_r;
  logic               live_r;   // low until the first edge out of reset
  logic               enq;
  logic               deq;

  assign wr_ptr_nxt = wr_ptr_r + 1'b1;   // wraps, depth is a power of two
  assign rdy_o      = live_r & ~full_r;
  assign val_o      = full_r | (rd_ptr_r != wr_ptr_r);
  assign data_o     = mem_r[rd_ptr_r];
  assign enq        = val_i & rdy_o;
  assign deq        = yumi_i & val_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      full_r   <= 1'b0;
      live_r   <= 1'b0;
    end else begin
      live_r <= 1'b1;
      if (enq) wr_ptr_r <= wr_ptr_nxt;
      if (deq) rd_ptr_r <= rd_ptr_r + 1'b1;
      // full only changes on a lone push or a lone pop
      if (enq != deq) full_r <= enq & (wr_ptr_nxt == rd_ptr_r);
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) mem_r[wr_ptr_r] <= data_i;
  end

endmodule

`default_nettype wire

/* logic/mesh_router.sv */
`timescale 1ns/1ps
`default_nettype none

module mesh_router #(
  parameter int fifo_els_p = 2
) (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  input  logic [tile_pkg::cord_w-1:0]                               my_x_i,
  input  logic [tile_pkg::cord_w-1:0]                               my_y_i,
  input  logic [tile_pkg::dir_south:tile_pkg::dir_proc]             in_val_i,
  input  logic [tile_pkg::dir_south:tile_pkg::dir_proc][tile_pkg::pkt_w-1:0] in_data_i,
  output logic [tile_pkg::dir_south:tile_pkg::dir_proc]             in_rdy_o,
  output logic [tile_pkg::dir_south:tile_pkg::dir_proc]             out_val_o,
  output logic [tile_pkg::dir_south:tile_pkg::dir_proc][tile_pkg::pkt_w-1:0] out_data_o,
  input  logic [tile_pkg::dir_south:tile_pkg::dir_proc]             out_rdy_i
);

  import tile_pkg::*;

  localparam int ptr_w = $clog2(dirs);

  logic [dirs-1:0]             head_val;
  logic [dirs-1:0][pkt_w-1:0]  head_data;
  logic [dirs-1:0]             head_yumi;
  logic [dirs-1:0][dirs-1:0]   head_req;     // [input][output]
  logic [dirs-1:0]             win_val;      // per output
  logic [dirs-1:0][ptr_w-1:0]  win_idx;
  logic [dirs-1:0][ptr_w-1:0]  rr_ptr_r;     // last input served
  logic [dirs-1:0]             out_val_r;
  logic [dirs-1:0][pkt_w-1:0]  out_data_r;
  logic [dirs-1:0]             out_load;

  // x first, then y
  function automatic dir_e route_dir(input logic [pkt_w-1:0]  pkt,
                                     input logic [cord_w-1:0] x,
                                     input logic [cord_w-1:0] y);
    logic [cord_w-1:0] dx;
    logic [cord_w-1:0] dy;
    dx = pkt[dst_x_lsb +: cord_w];
    dy = pkt[dst_y_lsb +: cord_w];
    if (dx > x)      return dir_east;
    else if (dx < x) return dir_west;
    else if (dy > y) return dir_south;
    else if (dy < y) return dir_north;
    else             return dir_proc;
  endfunction

  for (genvar i = 0; i < dirs; i++) begin : g_in
    link_fifo #(
      .width_p(pkt_w),
      .els_p  (fifo_els_p)
    ) fifo (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .val_i  (in_val_i[i]),
      .data_i (in_data_i[i]),
      .rdy_o  (in_rdy_o[i]),
      .val_o  (head_val[i]),
      .data_o (head_data[i]),
      .yumi_i (head_yumi[i])
    );
  end

  always_comb begin
    head_req = '0;
    for (int i = 0; i < dirs; i++) begin
      head_req[i][route_dir(head_data[i], my_x_i, my_y_i)] = head_val[i];
    end
  end

  // round robin, search starts one past the last winner
  always_comb begin
    int idx;
    for (int o = 0; o < dirs; o++) begin
      win_val[o] = 1'b0;
      win_idx[o] = rr_ptr_r[o];
      for (int k = 1; k <= dirs; k++) begin
        idx = int'(rr_ptr_r[o]) + k;
        if (idx >= dirs) idx = idx - dirs;
        if (!win_val[o] && head_req[idx][o]) begin
          win_val[o] = 1'b1;
          win_idx[o] = ptr_w'(idx);
        end
      end
    end
  end

  assign out_load = ~out_val_r | out_rdy_i;   // empty or draining

  always_comb begin
    head_yumi = '0;
    for (int o = 0; o < dirs; o++) begin
      if (win_val[o] && out_load[o]) head_yumi[win_idx[o]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_val_r <= '0;
      rr_ptr_r  <= '0;
    end else begin
      for (int o = 0; o < dirs; o++) begin
        if (out_load[o]) begin
          out_val_r[o] <= win_val[o];
          if (win_val[o]) rr_ptr_r[o] <= win_idx[o];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < dirs; o++) begin
      if (out_load[o] && win_val[o]) out_data_r[o] <= head_data[win_idx[o]];
    end
  end

  assign out_val_o  = out_val_r;
  assign out_data_o = out_data_r;

endmodule

`default_nettype wire

/* logic/remote_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module remote_mem #(
  parameter int dmem_words_p = 64
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic [tile_pkg::cord_w-1:0]  my_x_i,
  input  logic [tile_pkg::cord_w-1:0]  my_y_i,
  input  logic                         req_val_i,
  input  logic [tile_pkg::pkt_w-1:0]   req_data_i,
  output logic                         req_rdy_o,
  output logic                         resp_val_o,
  output logic [tile_pkg::pkt_w-1:0]   resp_data_o,
  input  logic                         resp_rdy_i,
  input  logic [tile_pkg::data_w-1:0]  acc_value_i,
  output logic                         acc_clr_o
);

  import tile_pkg::*;

  localparam int idx_w = (dmem_words_p > 1) ? $clog2(dmem_words_p) : 1;

  logic [data_w-1:0] mem_r [dmem_words_p];
  logic              live_r;
  logic              resp_val_r;
  logic [pkt_w-1:0]  resp_data_r;
  op_e               req_op;
  logic [addr_w-1:0] req_addr;
  logic [idx_w-1:0]  req_idx;
  logic [data_w-1:0] req_wdata;
  logic [data_w-1:0] rd_word;
  logic [pkt_w-1:0]  resp_pkt;
  logic              req_fire;
  logic              is_acc;
  logic              in_range;
  logic              do_write;
  logic              do_read;

  assign req_op    = op_e'(req_data_i[op_lsb +: op_w]);
  assign req_addr  = req_data_i[addr_lsb +: addr_w];
  assign req_idx   = req_addr[idx_w-1:0];
  assign req_wdata = req_data_i[data_lsb +: data_w];

  assign req_rdy_o = live_r & ~resp_val_r;   // stall while a response waits
  assign req_fire  = req_val_i & req_rdy_o;
  assign is_acc    = (req_addr == acc_addr);
  assign in_range  = (int'(req_addr) < dmem_words_p);
  assign do_write  = req_fire & (req_op == op_write);
  assign do_read   = req_fire & (req_op == op_read);
  // op_resp and unknown opcodes are simply dropped

  assign acc_clr_o = do_write & is_acc;

  always_comb begin
    if (is_acc)        rd_word = acc_value_i;
    else if (in_range) rd_word = mem_r[req_idx];
    else               rd_word = '0;   // hole above the memory
  end

  // reply goes back to the requester
  assign resp_pkt = {op_resp,
                     req_data_i[src_x_lsb +: cord_w],
                     req_data_i[src_y_lsb +: cord_w],
                     my_x_i,
                     my_y_i,
                     req_addr,
                     rd_word};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      live_r     <= 1'b0;
      resp_val_r <= 1'b0;
    end else begin
      live_r <= 1'b1;
      if (resp_val_r && resp_rdy_i) resp_val_r <= 1'b0;
      if (do_read) resp_val_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_read) resp_data_r <= resp_pkt;
    if (do_write && in_range && !is_acc) mem_r[req_idx] <= req_wdata;
  end

  assign resp_val_o  = resp_val_r;
  assign resp_data_o = resp_data_r;

endmodule

`default_nettype wire

/* logic/systolic_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module systolic_mac (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         row_val_i,
  input  logic [tile_pkg::sys_w-1:0]   row_msg_i,
  output logic                         row_rdy_o,
  input  logic                         col_val_i,
  input  logic [tile_pkg::sys_w-1:0]   col_msg_i,
  output logic                         col_rdy_o,
  output logic                         row_val_o,
  output logic [tile_pkg::sys_w-1:0]   row_msg_o,
  input  logic                         row_rdy_i,
  output logic                         col_val_o,
  output logic [tile_pkg::sys_w-1:0]   col_msg_o,
  input  logic                         col_rdy_i,
  input  logic                         acc_clr_i,
  output logic [tile_pkg::data_w-1:0]  acc_value_o
);

  import tile_pkg::*;

  logic              live_r;
  logic              row_val_r;
  logic [sys_w-1:0]  row_msg_r;
  logic              col_val_r;
  logic [sys_w-1:0]  col_msg_r;
  logic [data_w-1:0] acc_r;
  logic [data_w-1:0] product;
  logic              row_free;
  logic              col_free;
  logic              take;

  // forwarding slot can take a word if empty or emptied this cycle
  assign row_free = ~row_val_r | row_rdy_i;
  assign col_free = ~col_val_r | col_rdy_i;

  // a pair moves only as a pair
  assign take      = live_r & row_val_i & col_val_i & row_free & col_free;
  assign row_rdy_o = take;
  assign col_rdy_o = take;

  assign product = data_w'(row_msg_i) * data_w'(col_msg_i);   // unsigned 16x16

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      live_r    <= 1'b0;
      row_val_r <= 1'b0;
      col_val_r <= 1'b0;
      acc_r     <= '0;
    end else begin
      live_r <= 1'b1;
      if (row_rdy_i) row_val_r <= 1'b0;
      if (col_rdy_i) col_val_r <= 1'b0;
      if (take) begin
        row_val_r <= 1'b1;
        col_val_r <= 1'b1;
      end
      if (acc_clr_i)
        acc_r <= take ? product : '0;   // clear wins over the old sum
      else if (take)
        acc_r <= acc_r + product;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      row_msg_r <= row_msg_i;
      col_msg_r <= col_msg_i;
    end
  end

  assign row_val_o   = row_val_r;
  assign row_msg_o   = row_msg_r;
  assign col_val_o   = col_val_r;
  assign col_msg_o   = col_msg_r;
  assign acc_value_o = acc_r;

endmodule

`default_nettype wire

/* logic/manycore_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module manycore_tile #(
  parameter int fifo_els_p   = 2,
  parameter int dmem_words_p = 64
) (
  input  logic                                                       clk_i,
  input  logic                                                       rst_n_i,
  input  logic [tile_pkg::dir_south:tile_pkg::dir_west]              link_val_i,
  input  logic [tile_pkg::dir_south:tile_pkg::dir_west][tile_pkg::pkt_w-1:0] link_data_i,
  output logic [tile_pkg::dir_south:tile_pkg::dir_west]              link_rdy_o,
  output logic [tile_pkg::dir_south:tile_pkg::dir_west]              link_val_o,
  output logic [tile_pkg::dir_south:tile_pkg::dir_west][tile_pkg::pkt_w-1:0] link_data_o,
  input  logic [tile_pkg::dir_south:tile_pkg::dir_west]              link_rdy_i,
  input  logic                                                       row_val_i,
  input  logic [tile_pkg::sys_w-1:0]                                 row_msg_i,
  output logic                                                       row_rdy_o,
  input  logic                                                       col_val_i,
  input  logic [tile_pkg::sys_w-1:0]                                 col_msg_i,
  output logic                                                       col_rdy_o,
  output logic                                                       row_val_o,
  output logic [tile_pkg::sys_w-1:0]                                 row_msg_o,
  input  logic                                                       row_rdy_i,
  output logic                                                       col_val_o,
  output logic [tile_pkg::sys_w-1:0]                                 col_msg_o,
  input  logic                                                       col_rdy_i,
  input  logic [tile_pkg::cord_w-1:0]                                my_x_i,
  input  logic [tile_pkg::cord_w-1:0]                                my_y_i
);

  import tile_pkg::*;

  logic                        rst_n_r;   // local copy, eases reset fanout
  logic [dirs-1:0]             rtr_in_val;
  logic [dirs-1:0][pkt_w-1:0]  rtr_in_data;
  logic [dirs-1:0]             rtr_in_rdy;
  logic [dirs-1:0]             rtr_out_val;
  logic [dirs-1:0][pkt_w-1:0]  rtr_out_data;
  logic [dirs-1:0]             rtr_out_rdy;
  logic                        proc_val;
  logic [pkt_w-1:0]            proc_data;
  logic                        proc_rdy;
  logic                        resp_val;
  logic [pkt_w-1:0]            resp_data;
  logic                        resp_rdy;
  logic                        acc_clr;
  logic [data_w-1:0]           acc_value;

  always_ff @(posedge clk_i) begin
    rst_n_r <= rst_n_i;
  end

  // mesh links on slots west..south, memory on the proc slot
  assign rtr_in_val[dir_south:dir_west]   = link_val_i;
  assign rtr_in_data[dir_south:dir_west]  = link_data_i;
  assign link_rdy_o                       = rtr_in_rdy[dir_south:dir_west];
  assign link_val_o                       = rtr_out_val[dir_south:dir_west];
  assign link_data_o                      = rtr_out_data[dir_south:dir_west];
  assign rtr_out_rdy[dir_south:dir_west]  = link_rdy_i;

  assign proc_val               = rtr_out_val[dir_proc];
  assign proc_data              = rtr_out_data[dir_proc];
  assign rtr_out_rdy[dir_proc]  = proc_rdy;
  assign rtr_in_val[dir_proc]   = resp_val;
  assign rtr_in_data[dir_proc]  = resp_data;
  assign resp_rdy               = rtr_in_rdy[dir_proc];

  mesh_router #(
    .fifo_els_p(fifo_els_p)
  ) rtr (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_r),
    .my_x_i    (my_x_i),
    .my_y_i    (my_y_i),
    .in_val_i  (rtr_in_val),
    .in_data_i (rtr_in_data),
    .in_rdy_o  (rtr_in_rdy),
    .out_val_o (rtr_out_val),
    .out_data_o(rtr_out_data),
    .out_rdy_i (rtr_out_rdy)
  );

  remote_mem #(
    .dmem_words_p(dmem_words_p)
  ) mem (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_r),
    .my_x_i     (my_x_i),
    .my_y_i     (my_y_i),
    .req_val_i  (proc_val),
    .req_data_i (proc_data),
    .req_rdy_o  (proc_rdy),
    .resp_val_o (resp_val),
    .resp_data_o(resp_data),
    .resp_rdy_i (resp_rdy),
    .acc_value_i(acc_value),
    .acc_clr_o  (acc_clr)
  );

  systolic_mac mac (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_r),
    .row_val_i  (row_val_i),
    .row_msg_i  (row_msg_i),
    .row_rdy_o  (row_rdy_o),
    .col_val_i  (col_val_i),
    .col_msg_i  (col_msg_i),
    .col_rdy_o  (col_rdy_o),
    .row_val_o  (row_val_o),
    .row_msg_o  (row_msg_o),
    .row_rdy_i  (row_rdy_i),
    .col_val_o  (col_val_o),
    .col_msg_o  (col_msg_o),
    .col_rdy_i  (col_rdy_i),
    .acc_clr_i  (acc_clr),
    .acc_value_o(acc_value)
  );

endmodule

`default_nettype wire

/* bench/tile_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_chk (
  input logic                                                       clk_i,
  input logic                                                       rst_n_i,   // registered copy
  input logic [tile_pkg::dir_south:tile_pkg::dir_west]              link_val_o,
  input logic [tile_pkg::dir_south:tile_pkg::dir_west][tile_pkg::pkt_w-1:0] link_data_o,
  input logic [tile_pkg::dir_south:tile_pkg::dir_west]              link_rdy_i,
  input logic [tile_pkg::dir_south:tile_pkg::dir_west]              link_rdy_o,
  input logic                                                       row_val_o,
  input logic [tile_pkg::sys_w-1:0]                                 row_msg_o,
  input logic                                                       row_rdy_i,
  input logic                                                       col_val_o,
  input logic [tile_pkg::sys_w-1:0]                                 col_msg_o,
  input logic                                                       col_rdy_i,
  input logic                                                       row_rdy_o,
  input logic                                                       col_rdy_o
);

  import tile_pkg::*;

  int fail_cnt = 0;

  // reset seen on two edges, so every register has been cleared
  a_quiet_in_reset: assert property (@(posedge clk_i)
    (!rst_n_i && !$past(rst_n_i)) |->
      (link_val_o == '0 && !row_val_o && !col_val_o &&
       link_rdy_o == '0 && !row_rdy_o && !col_rdy_o))
    else begin
      $error("valid or ready high during reset");
      fail_cnt++;
    end

  for (genvar p = int'(dir_west); p <= int'(dir_south); p++) begin : g_link
    a_link_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (link_val_o[p] && !link_rdy_i[p]) |=> (link_val_o[p] && $stable(link_data_o[p])))
      else begin
        $error("link output %0d dropped or changed a stalled word", p);
        fail_cnt++;
      end
  end

  a_row_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (row_val_o && !row_rdy_i) |=> (row_val_o && $stable(row_msg_o)))
    else begin
      $error("row output dropped or changed a stalled message");
      fail_cnt++;
    end

  a_col_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (col_val_o && !col_rdy_i) |=> (col_val_o && $stable(col_msg_o)))
    else begin
      $error("column output dropped or changed a stalled message");
      fail_cnt++;
    end

  a_val_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown({link_val_o, row_val_o, col_val_o}))
    else begin
      $error("unknown value on a valid output");
      fail_cnt++;
    end

endmodule

bind manycore_tile tile_chk chk (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_r),
  .link_val_o (link_val_o),
  .link_data_o(link_data_o),
  .link_rdy_i (link_rdy_i),
  .link_rdy_o (link_rdy_o),
  .row_val_o  (row_val_o),
  .row_msg_o  (row_msg_o),
  .row_rdy_i  (row_rdy_i),
  .col_val_o  (col_val_o),
  .col_msg_o  (col_msg_o),
  .col_rdy_i  (col_rdy_i),
  .row_rdy_o  (row_rdy_o),
  .col_rdy_o  (col_rdy_o)
);

`default_nettype wire

/* bench/tile_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_tb;

  import tile_pkg::*;

  localparam int max_cycles = 4000;   // roughly three times the whole run
  localparam int burst_n    = 12;     // packets per input in the mixed test
  localparam int pair_n     = 20;
  localparam int my_x       = 1;
  localparam int my_y       = 1;

  logic                                  clk_i = 1'b0;
  logic                                  rst_n_i;
  logic [dir_south:dir_west]             link_val_i;
  logic [dir_south:dir_west][pkt_w-1:0]  link_data_i;
  logic [dir_south:dir_west]             link_rdy_o;
  logic [dir_south:dir_west]             link_val_o;
  logic [dir_south:dir_west][pkt_w-1:0]  link_data_o;
  logic [dir_south:dir_west]             link_rdy_i = '1;
  logic                                  row_val_i;
  logic [sys_w-1:0]                      row_msg_i;
  logic                                  row_rdy_o;
  logic                                  col_val_i;
  logic [sys_w-1:0]                      col_msg_i;
  logic                                  col_rdy_o;
  logic                                  row_val_o;
  logic [sys_w-1:0]                      row_msg_o;
  logic                                  row_rdy_i = 1'b1;
  logic                                  col_val_o;
  logic [sys_w-1:0]                      col_msg_o;
  logic                                  col_rdy_i = 1'b1;

  logic [31:0]       data_seed;
  logic [31:0]       rdy_seed = 32'd94;   // separate stream for the ready pattern
  logic              rand_rdy = 1'b0;
  logic              run_mon = 1'b0;
  int                errors = 0;
  int                pending = 0;          // words still expected anywhere
  int                cycles = 0;
  logic [data_w-1:0] model_mem [64];
  logic [data_w-1:0] acc_model;
  logic [pkt_w-1:0]  exp_q [dirs*dirs][$];   // [out*dirs + in]
  logic [sys_w-1:0]  row_q [$];
  logic [sys_w-1:0]  col_q [$];
  logic [pkt_w-1:0]  burst [dirs][burst_n];

  manycore_tile #(
    .fifo_els_p  (2),
    .dmem_words_p(64)
  ) uut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .link_val_i (link_val_i),
    .link_data_i(link_data_i),
    .link_rdy_o (link_rdy_o),
    .link_val_o (link_val_o),
    .link_data_o(link_data_o),
    .link_rdy_i (link_rdy_i),
    .row_val_i  (row_val_i),
    .row_msg_i  (row_msg_i),
    .row_rdy_o  (row_rdy_o),
    .col_val_i  (col_val_i),
    .col_msg_i  (col_msg_i),
    .col_rdy_o  (col_rdy_o),
    .row_val_o  (row_val_o),
    .row_msg_o  (row_msg_o),
    .row_rdy_i  (row_rdy_i),
    .col_val_o  (col_val_o),
    .col_msg_o  (col_msg_o),
    .col_rdy_i  (col_rdy_i),
    .my_x_i     (4'(my_x)),
    .my_y_i     (4'(my_y))
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    data_seed = xorshift(data_seed);
    return data_seed;
  endfunction

  function automatic logic [pkt_w-1:0] make_pkt(input op_e op, input int dx, input int dy,
                                                input int sx, input int sy,
                                                input logic [addr_w-1:0] a,
                                                input logic [data_w-1:0] d);
    return {op, cord_w'(dx), cord_w'(dy), cord_w'(sx), cord_w'(sy), a, d};
  endfunction

  // x before y, seen from tile (1,1)
  function automatic int expect_port(input logic [pkt_w-1:0] pkt);
    int dx;
    int dy;
    dx = int'(pkt[dst_x_lsb +: cord_w]);
    dy = int'(pkt[dst_y_lsb +: cord_w]);
    if (dx != my_x) return (dx > my_x) ? dir_east : dir_west;
    if (dy != my_y) return (dy > my_y) ? dir_south : dir_north;
    return dir_proc;
  endfunction

  task automatic send_link(input int p, input logic [pkt_w-1:0] pkt);
    logic took;
    link_val_i[p]  = 1'b1;
    link_data_i[p] = pkt;
    took = 1'b0;
    while (!took) begin
      @(negedge clk_i);
      took = link_rdy_o[p];   // ready only moves on a clock edge
      @(posedge clk_i);
    end
    #1;
    link_val_i[p] = 1'b0;
  endtask

  task automatic inject(input int p, input logic [pkt_w-1:0] pkt);
    exp_q[expect_port(pkt) * dirs + p].push_back(pkt);
    pending++;
    send_link(p, pkt);
  endtask

  task automatic send_burst(input int p);
    for (int i = 0; i < burst_n; i++) send_link(p, burst[p][i]);
  endtask

  task automatic mem_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    if (a == acc_addr) acc_model = '0;
    else if (a < 64) model_mem[a[5:0]] = d;
    send_link(dir_west, make_pkt(op_write, my_x, my_y, 0, dir_west, a, d));
  endtask

  task automatic mem_read(input logic [addr_w-1:0] a);
    logic [data_w-1:0] d;
    if (a == acc_addr) d = acc_model;
    else if (a < 64) d = model_mem[a[5:0]];
    else d = '0;   // hole above the memory
    exp_q[int'(dir_west) * dirs + dir_proc].push_back(
      make_pkt(op_resp, 0, my_y, my_x, my_y, a, d));
    pending++;
    send_link(dir_west, make_pkt(op_read, my_x, my_y, 0, dir_west, a, next_rand()));
  endtask

  task automatic send_pair(input logic [sys_w-1:0] r, input logic [sys_w-1:0] c);
    logic took;
    row_val_i = 1'b1;
    row_msg_i = r;
    col_val_i = 1'b1;
    col_msg_i = c;
    row_q.push_back(r);
    col_q.push_back(c);
    pending += 2;
    acc_model = acc_model + 32'(r) * 32'(c);
    took = 1'b0;
    while (!took) begin
      @(negedge clk_i);
      took = row_rdy_o & col_rdy_o;
      @(posedge clk_i);
    end
    #1;
    row_val_i = 1'b0;
    col_val_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (pending != 0) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_link(input int o, input logic [pkt_w-1:0] pkt);
    int               src;
    int               k;
    logic             known;
    logic [pkt_w-1:0] want;
    if (pkt[src_x_lsb +: cord_w] == my_x && pkt[src_y_lsb +: cord_w] == my_y) src = dir_proc;
    else src = int'(pkt[src_y_lsb +: cord_w]);   // injected words carry their input here
    k = o * dirs + ((src < dirs) ? src : 0);
    known = (src < dirs) && (exp_q[k].size() > 0);
    assert (known) else begin
      $display("unexpected word %h left on output %0d at %0t ns", pkt, o, $time);
      errors++;
    end
    if (known) begin
      want = exp_q[k].pop_front();
      pending--;
      assert (pkt == want) else begin
        $display("[ERROR] %0t ns: output %0d got %h, expected %h", $time, o, pkt, want);
        errors++;
      end
    end
  endtask

  task automatic check_sys(input logic is_row, input logic [sys_w-1:0] msg);
    logic [sys_w-1:0] want;
    int               n;
    n = is_row ? row_q.size() : col_q.size();
    assert (n > 0) else begin
      $display("unexpected %s message %h at %0t ns", is_row ? "row" : "column", msg, $time);
      errors++;
    end
    if (n > 0) begin
      if (is_row) want = row_q.pop_front();
      else want = col_q.pop_front();
      pending--;
      assert (msg == want) else begin
        $display("[ERROR] %0t ns: %s output got %h, expected %h", $time,
                 is_row ? "row" : "column", msg, want);
        errors++;
      end
    end
  endtask

  // output ready pattern, new value just after each edge
  always @(posedge clk_i) begin
    logic rand_now;
    rand_now = rand_rdy;   // mode as it stood at the edge
    #1;
    if (rand_now) begin
      rdy_seed   = xorshift(rdy_seed);
      link_rdy_i = rdy_seed[3:0] | rdy_seed[7:4];
      row_rdy_i  = rdy_seed[8];
      col_rdy_i  = rdy_seed[9] | rdy_seed[10];
    end else begin
      link_rdy_i = '1;
      row_rdy_i  = 1'b1;
      col_rdy_i  = 1'b1;
    end
  end

  // outputs are steady mid cycle
  always @(negedge clk_i) begin
    if (run_mon) begin
      for (int o = dir_west; o <= dir_south; o++) begin
        if (link_val_o[o] && link_rdy_i[o]) check_link(o, link_data_o[o]);
      end
      if (row_val_o && row_rdy_i) check_sys(1'b1, row_msg_o);
      if (col_val_o && col_rdy_i) check_sys(1'b0, col_msg_o);
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    logic [31:0]      w;
    logic [pkt_w-1:0] pkt;
    link_val_i  = '0;
    link_data_i = '0;
    row_val_i   = 1'b0;
    row_msg_i   = '0;
    col_val_i   = 1'b0;
    col_msg_i   = '0;
    rst_n_i     = 1'b0;
    data_seed   = 32'd94;
    acc_model   = '0;
    repeat (2) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    @(posedge clk_i);   // internal reset ends here
    #1 run_mon = 1'b1;

    // nothing may leave an idle tile
    repeat (3) begin
      @(negedge clk_i);
      assert (link_val_o == '0 && !row_val_o && !col_val_o) else begin
        $display("[ERROR] %0t ns: valid output high with no traffic", $time);
        errors++;
      end
    end
    @(posedge clk_i);
    #1;

    inject(dir_west, make_pkt(op_write, 3, 1, 0, dir_west, 8'h21, next_rand()));
    inject(dir_west, make_pkt(op_write, 0, 1, 0, dir_west, 8'h22, next_rand()));
    inject(dir_west, make_pkt(op_write, 1, 3, 0, dir_west, 8'h23, next_rand()));
    inject(dir_west, make_pkt(op_write, 1, 0, 0, dir_west, 8'h24, next_rand()));
    wait_drain();

    mem_write(8'd3, next_rand());
    mem_write(8'd40, next_rand());
    mem_write(8'd63, next_rand());
    mem_write(8'd3, next_rand());   // overwrite, last data must win
    mem_write(8'd70, next_rand());
    mem_write(8'd200, next_rand());
    mem_read(8'd3);
    mem_read(8'd40);
    mem_read(8'd63);
    mem_read(8'd70);
    mem_read(8'd200);
    wait_drain();

    // all four links at once, several inputs per output
    for (int p = dir_west; p <= dir_south; p++) begin
      for (int i = 0; i < burst_n; i++) begin
        w = next_rand();
        case (w[1:0])
          2'd0:    pkt = make_pkt(op_write, 3, my_y, 0, p, w[15:8], w);
          2'd1:    pkt = make_pkt(op_write, 0, my_y, 0, p, w[15:8], w);
          2'd2:    pkt = make_pkt(op_write, my_x, 3, 0, p, w[15:8], w);
          default: pkt = make_pkt(op_write, my_x, 0, 0, p, w[15:8], w);
        endcase
        exp_q[expect_port(pkt) * dirs + p].push_back(pkt);
        pending++;
        burst[p][i] = pkt;
      end
    end
    rand_rdy = 1'b1;
    fork
      send_burst(dir_west);
      send_burst(dir_east);
      send_burst(dir_north);
      send_burst(dir_south);
    join
    wait_drain();

    for (int i = 0; i < pair_n; i++) begin
      w = next_rand();
      send_pair(w[15:0], w[31:16]);
    end
    wait_drain();
    mem_read(acc_addr);
    mem_write(acc_addr, next_rand());   // clears the sum
    mem_read(acc_addr);
    wait_drain();

    $display("errors: %0d data, %0d protocol", errors, uut.chk.fail_cnt);
    if (errors == 0 && uut.chk.fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
logic/tile_pkg.sv
logic/link_fifo.sv
logic/mesh_router.sv
logic/remote_mem.sv
logic/systolic_mac.sv
logic/manycore_tile.sv
bench/tile_chk.sv
bench/tile_tb.sv

/* run.sh */
#!/bin/sh
# build the tile testbench with Verilator, then run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tile_tb -f all.f -o tile_sim \
  || { echo "build failed"; exit 1; }
# keep going past assertion errors so the testbench prints its verdict
out=$(./obj_dir/tile_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
